// File: verilog/gpmc_pkg.sv
package gpmc_pkg;

   // GPMC bus geometry
   localparam int EM_ADR_W = 10;       // Word address pins A10..A1
   localparam int EM_DAT_W = 16;
   localparam int EM_SEL_W = 2;        // Byte lanes

   // Wishbone byte address, word address with a zero appended
   localparam int WB_ADR_W = EM_ADR_W + 1;

   // Register file map, index taken from address bits 3..1
   localparam int REG_IDX_W = 3;

   localparam logic [REG_IDX_W-1:0] REG_ID     = REG_IDX_W'(0);
   localparam logic [REG_IDX_W-1:0] REG_CTRL   = REG_IDX_W'(1);
   localparam logic [REG_IDX_W-1:0] REG_STATUS = REG_IDX_W'(2);
   // Indices 3 to 7 are scratch

   localparam logic [EM_DAT_W-1:0] GPMC_ID = 16'h6b21;  // Read-only board ID

   // Wishbone master cycle state
   typedef enum logic [1:0]
   {
      WB_IDLE  = 2'd0,
      WB_READ  = 2'd1,
      WB_WRITE = 2'd2
   } wb_state_e;

endpackage

// File: verilog/ram_2port.sv
`timescale 1ns/1ps

module ram_2port
(
   input  logic                          wb_clk,
   input  logic                          arst_n_i,
   // Port A, GPMC side
   input  logic                          ena_i,
   input  logic                          wea_i,
   input  logic [gpmc_pkg::EM_ADR_W-1:0] addra_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] dia_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] doa_o,
   // Port B, fabric side
   input  logic                          enb_i,
   input  logic                          web_i,
   input  logic [gpmc_pkg::EM_ADR_W-1:0] addrb_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] dib_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] dob_o
);
   import gpmc_pkg::*;

   localparam int DEPTH = 2**EM_ADR_W;

   logic [EM_DAT_W-1:0] mem [0:DEPTH-1];

   // Both write ports in one process so the array has a single driver
   always @(posedge wb_clk)
   begin
      if (ena_i && wea_i)
         mem[addra_i] <= dia_i;
      if (enb_i && web_i)
         mem[addrb_i] <= dib_i;
   end

   // Registered read, write-first on each port
   always_ff @(posedge wb_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         doa_o <= '0;
         dob_o <= '0;
      end
      else
      begin
         if (ena_i)
            doa_o <= wea_i ? dia_i : mem[addra_i];
         if (enb_i)
            dob_o <= web_i ? dib_i : mem[addrb_i];
      end
   end

endmodule

// File: verilog/gpmc_wb_master.sv
`timescale 1ns/1ps

module gpmc_wb_master
(
   input  logic                          wb_clk,
   input  logic                          arst_n_i,
   // GPMC chip select 6 side
   input  logic [gpmc_pkg::EM_ADR_W-1:0] em_a_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] em_d_i,
   input  logic [gpmc_pkg::EM_SEL_W-1:0] em_nbe_i,
   input  logic                          em_ncs6_i,
   input  logic                          em_nwe_i,
   input  logic                          em_noe_i,
   // Wishbone master
   output logic [gpmc_pkg::WB_ADR_W-1:0] wb_adr_o,
   output logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_o,
   output logic [gpmc_pkg::EM_SEL_W-1:0] wb_sel_o,
   output logic                          wb_we_o,
   output logic                          wb_stb_o,
   output logic                          wb_cyc_o,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_i,
   input  logic                          wb_ack_i,
   // Last read data for the GPMC data mux
   output logic [gpmc_pkg::EM_DAT_W-1:0] rd_dat_o
);
   import gpmc_pkg::*;

   logic [1:0] cs_del;
   logic [1:0] we_del;
   logic [1:0] oe_del;
   logic       cs_fall;
   logic       we_fall;
   logic       oe_fall;
   logic       launch;
   wb_state_e  wb_state;

   // Two-flop delay lines, idle high out of reset so no false edge
   always_ff @(posedge wb_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         cs_del <= 2'b11;
         we_del <= 2'b11;
         oe_del <= 2'b11;
      end
      else
      begin
         cs_del <= {cs_del[0], em_ncs6_i};
         we_del <= {we_del[0], em_nwe_i};
         oe_del <= {oe_del[0], em_noe_i};
      end
   end

   assign cs_fall = (cs_del == 2'b10);  // Older high, newer low
   assign we_fall = (we_del == 2'b10);
   assign oe_fall = (oe_del == 2'b10);

   // Strobes arriving mid-cycle are dropped
   assign launch = ~cs_del[0] & (we_fall | oe_fall) & (wb_state == WB_IDLE);

   always_ff @(posedge wb_clk)
   begin
      if (cs_fall)
         wb_adr_o <= {em_a_i, 1'b0};
      if (we_fall)
      begin
         wb_dat_o <= em_d_i;
         wb_sel_o <= ~em_nbe_i;
      end
      if (wb_ack_i && (wb_state == WB_READ))
         rd_dat_o <= wb_dat_i;  // Held until the next read
   end

   always_ff @(posedge wb_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         wb_state <= WB_IDLE;
      else
      begin
         case (wb_state)
            WB_IDLE:
               if (launch)
                  wb_state <= we_fall ? WB_WRITE : WB_READ;  // Write wins a tie
            WB_READ, WB_WRITE:
               if (wb_ack_i)
                  wb_state <= WB_IDLE;
            default:
               wb_state <= WB_IDLE;
         endcase
      end
   end

   // Single classic cycle, stb and cyc share one source
   assign wb_stb_o = (wb_state != WB_IDLE);
   assign wb_cyc_o = wb_stb_o;
   assign wb_we_o  = (wb_state == WB_WRITE);

endmodule

// File: verilog/gpmc.sv
`timescale 1ns/1ps

module gpmc
(
   input  logic                          wb_clk,
   input  logic                          arst_n_i,
   // GPMC bus, pad split into in, out and enable
   input  logic [gpmc_pkg::EM_ADR_W-1:0] em_a_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] em_d_i,
   input  logic [gpmc_pkg::EM_SEL_W-1:0] em_nbe_i,
   input  logic                          em_ncs4_i,
   input  logic                          em_ncs6_i,
   input  logic                          em_nwe_i,
   input  logic                          em_noe_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] em_d_o,
   output logic                          em_d_oe_o,
   // Wishbone master
   output logic [gpmc_pkg::WB_ADR_W-1:0] wb_adr_o,
   output logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_o,
   output logic [gpmc_pkg::EM_SEL_W-1:0] wb_sel_o,
   output logic                          wb_we_o,
   output logic                          wb_stb_o,
   output logic                          wb_cyc_o,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_i,
   input  logic                          wb_ack_i,
   // Fabric RAM port
   input  logic                          fab_en_i,
   input  logic                          fab_we_i,
   input  logic [gpmc_pkg::EM_ADR_W-1:0] fab_adr_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] fab_dat_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] fab_dat_o
);
   import gpmc_pkg::*;

   logic [EM_DAT_W-1:0] ram_dat;
   logic [EM_DAT_W-1:0] wb_rd_dat;

   assign em_d_oe_o = ~em_noe_i & (~em_ncs4_i | ~em_ncs6_i);
   assign em_d_o    = ~em_ncs4_i ? ram_dat : wb_rd_dat;  // CS4 has priority

   // CS4 bulk data buffer
   ram_2port u_ram
   (
      .wb_clk   (wb_clk),
      .arst_n_i (arst_n_i),
      .ena_i    (~em_ncs4_i),
      .wea_i    (~em_ncs4_i & ~em_nwe_i),
      .addra_i  (em_a_i),
      .dia_i    (em_d_i),
      .doa_o    (ram_dat),
      .enb_i    (fab_en_i),
      .web_i    (fab_we_i),
      .addrb_i  (fab_adr_i),
      .dib_i    (fab_dat_i),
      .dob_o    (fab_dat_o)
   );

   // CS6 control path
   gpmc_wb_master u_wb_master
   (
      .wb_clk    (wb_clk),
      .arst_n_i  (arst_n_i),
      .em_a_i    (em_a_i),
      .em_d_i    (em_d_i),
      .em_nbe_i  (em_nbe_i),
      .em_ncs6_i (em_ncs6_i),
      .em_nwe_i  (em_nwe_i),
      .em_noe_i  (em_noe_i),
      .wb_adr_o  (wb_adr_o),
      .wb_dat_o  (wb_dat_o),
      .wb_sel_o  (wb_sel_o),
      .wb_we_o   (wb_we_o),
      .wb_stb_o  (wb_stb_o),
      .wb_cyc_o  (wb_cyc_o),
      .wb_dat_i  (wb_dat_i),
      .wb_ack_i  (wb_ack_i),
      .rd_dat_o  (wb_rd_dat)
   );

endmodule

// File: verilog/wb_ctrl_regs.sv
`timescale 1ns/1ps

module wb_ctrl_regs
(
   input  logic                          wb_clk,
   input  logic                          arst_n_i,
   input  logic [gpmc_pkg::WB_ADR_W-1:0] wb_adr_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_i,
   input  logic [gpmc_pkg::EM_SEL_W-1:0] wb_sel_i,
   input  logic                          wb_we_i,
   input  logic                          wb_stb_i,
   input  logic                          wb_cyc_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] wb_dat_o,
   output logic                          wb_ack_o,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] status_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] ctrl_reg_o
);
   import gpmc_pkg::*;

   logic [REG_IDX_W-1:0] reg_idx;
   logic                 access;
   logic                 wr_en;
   logic [EM_DAT_W-1:0]  ctrl_q;
   logic [EM_DAT_W-1:0]  scratch_q [3:7];
   logic [EM_DAT_W-1:0]  rd_mux;

   // Byte-lane merge of new data into an old word
   function automatic logic [EM_DAT_W-1:0] lane_merge(input logic [EM_DAT_W-1:0] old_v,
                                                      input logic [EM_DAT_W-1:0] new_v,
                                                      input logic [EM_SEL_W-1:0] sel);
      logic [EM_DAT_W-1:0] res;
      res = old_v;
      for (int i = 0; i < EM_SEL_W; i++)
         if (sel[i])
            res[i*8 +: 8] = new_v[i*8 +: 8];
      return res;
   endfunction

   assign reg_idx = wb_adr_i[REG_IDX_W:1];
   assign access  = wb_stb_i & wb_cyc_i & ~wb_ack_o;  // No back-to-back acks
   assign wr_en   = access & wb_we_i;

   always_comb
   begin
      case (reg_idx)
         REG_ID:     rd_mux = GPMC_ID;
         REG_CTRL:   rd_mux = ctrl_q;
         REG_STATUS: rd_mux = status_i;
         default:    rd_mux = scratch_q[reg_idx];
      endcase
   end

   always_ff @(posedge wb_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wb_ack_o <= 1'b0;
         ctrl_q   <= '0;
         for (int i = 3; i <= 7; i++)
            scratch_q[i] <= '0;
      end
      else
      begin
         wb_ack_o <= access;
         if (wr_en && (reg_idx == REG_CTRL))
            ctrl_q <= lane_merge(ctrl_q, wb_dat_i, wb_sel_i);
         else if (wr_en && (reg_idx > REG_STATUS))
            scratch_q[reg_idx] <= lane_merge(scratch_q[reg_idx], wb_dat_i, wb_sel_i);
      end
   end

   // Status sampled together with the ack
   always_ff @(posedge wb_clk)
      if (access)
         wb_dat_o <= rd_mux;

   assign ctrl_reg_o = ctrl_q;

endmodule

// File: verilog/gpmc_bridge_top.sv
`timescale 1ns/1ps

module gpmc_bridge_top
(
   input  logic                          wb_clk,
   input  logic                          arst_n_i,
   input  logic [gpmc_pkg::EM_ADR_W-1:0] em_a_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] em_d_i,
   input  logic [gpmc_pkg::EM_SEL_W-1:0] em_nbe_i,
   input  logic                          em_ncs4_i,
   input  logic                          em_ncs6_i,
   input  logic                          em_nwe_i,
   input  logic                          em_noe_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] em_d_o,
   output logic                          em_d_oe_o,
   input  logic                          fab_en_i,
   input  logic                          fab_we_i,
   input  logic [gpmc_pkg::EM_ADR_W-1:0] fab_adr_i,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] fab_dat_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] fab_dat_o,
   input  logic [gpmc_pkg::EM_DAT_W-1:0] status_i,
   output logic [gpmc_pkg::EM_DAT_W-1:0] ctrl_reg_o
);
   import gpmc_pkg::*;

   // Internal Wishbone bus
   logic [WB_ADR_W-1:0] wb_adr;
   logic [EM_DAT_W-1:0] wb_dat_mosi;
   logic [EM_DAT_W-1:0] wb_dat_miso;
   logic [EM_SEL_W-1:0] wb_sel;
   logic                wb_we;
   logic                wb_stb;
   logic                wb_cyc;
   logic                wb_ack;

   gpmc u_gpmc
   (
      .wb_clk (wb_clk), .arst_n_i (arst_n_i),
      .em_a_i (em_a_i), .em_d_i (em_d_i), .em_nbe_i (em_nbe_i),
      .em_ncs4_i (em_ncs4_i), .em_ncs6_i (em_ncs6_i),
      .em_nwe_i (em_nwe_i), .em_noe_i (em_noe_i),
      .em_d_o (em_d_o), .em_d_oe_o (em_d_oe_o),
      .wb_adr_o (wb_adr), .wb_dat_o (wb_dat_mosi), .wb_sel_o (wb_sel),
      .wb_we_o (wb_we), .wb_stb_o (wb_stb), .wb_cyc_o (wb_cyc),
      .wb_dat_i (wb_dat_miso), .wb_ack_i (wb_ack),
      .fab_en_i (fab_en_i), .fab_we_i (fab_we_i), .fab_adr_i (fab_adr_i),
      .fab_dat_i (fab_dat_i), .fab_dat_o (fab_dat_o)
   );

   wb_ctrl_regs u_regs
   (
      .wb_clk (wb_clk), .arst_n_i (arst_n_i),
      .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_mosi), .wb_sel_i (wb_sel),
      .wb_we_i (wb_we), .wb_stb_i (wb_stb), .wb_cyc_i (wb_cyc),
      .wb_dat_o (wb_dat_miso), .wb_ack_o (wb_ack),
      .status_i (status_i), .ctrl_reg_o (ctrl_reg_o)
   );

endmodule

// File: verification/gpmc_bridge_properties.sv
`timescale 1ns/1ps

module gpmc_bridge_properties
(
   input logic                wb_clk,
   input logic                arst_n_i,
   input logic                wb_stb_i,
   input logic                wb_cyc_i,
   input logic                wb_ack_i,
   input gpmc_pkg::wb_state_e wb_state_i
);
   import gpmc_pkg::*;

   // Slave answers only an open strobe
   ack_needs_stb: assert property (@(posedge wb_clk) disable iff (!arst_n_i)
      wb_ack_i |-> wb_stb_i)
      else $error("wishbone ack without stb");

   stb_holds: assert property (@(posedge wb_clk) disable iff (!arst_n_i)
      (wb_stb_i && !wb_ack_i) |=> wb_stb_i)
      else $error("wishbone stb dropped before ack");

   cyc_is_stb: assert property (@(posedge wb_clk) disable iff (!arst_n_i)
      wb_cyc_i == wb_stb_i)
      else $error("wishbone cyc differs from stb");

   // Single cycle per strobe, so back to idle right after ack
   idle_after_ack: assert property (@(posedge wb_clk) disable iff (!arst_n_i)
      wb_ack_i |=> (wb_state_i == WB_IDLE))
      else $error("master not idle after ack");

endmodule

bind gpmc_wb_master gpmc_bridge_properties u_props
(
   .wb_clk     (wb_clk),
   .arst_n_i   (arst_n_i),
   .wb_stb_i   (wb_stb_o),
   .wb_cyc_i   (wb_cyc_o),
   .wb_ack_i   (wb_ack_i),
   .wb_state_i (wb_state)
);

// File: verification/tb_gpmc_bridge.sv
`timescale 1ns/1ps

module tb_gpmc_bridge;
   import gpmc_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int HOLD_CYC    = 10;   // Strobe width, above the 8 cycle minimum
   localparam int NUM_WORDS   = 4;
   // Strobes per test 3 + 8 + 4 + 6 + 4 + 10
   localparam int NUM_STROBES = 35;
   localparam int TIMEOUT_CYC = 2 * NUM_STROBES * HOLD_CYC;

   logic                wb_clk;
   logic                arst_n_i;
   logic [EM_ADR_W-1:0] em_a_i;
   logic [EM_DAT_W-1:0] em_d_i;
   logic [EM_SEL_W-1:0] em_nbe_i;
   logic                em_ncs4_i;
   logic                em_ncs6_i;
   logic                em_nwe_i;
   logic                em_noe_i;
   logic [EM_DAT_W-1:0] em_d_o;
   logic                em_d_oe_o;
   logic                fab_en_i;
   logic                fab_we_i;
   logic [EM_ADR_W-1:0] fab_adr_i;
   logic [EM_DAT_W-1:0] fab_dat_i;
   logic [EM_DAT_W-1:0] fab_dat_o;
   logic [EM_DAT_W-1:0] status_i;
   logic [EM_DAT_W-1:0] ctrl_reg_o;

   logic [15:0]         lfsr_q;
   logic [EM_DAT_W-1:0] ram_model [0:2**EM_ADR_W-1];
   logic [EM_DAT_W-1:0] ctrl_model;
   string               test_name;
   int                  test_cnt;
   int                  fail_cnt;
   int                  check_cnt;
   int                  err_cnt;
   int                  test_err;
   int                  cycle_cnt;

   gpmc_bridge_top UUT
   (
      .wb_clk (wb_clk), .arst_n_i (arst_n_i),
      .em_a_i (em_a_i), .em_d_i (em_d_i), .em_nbe_i (em_nbe_i),
      .em_ncs4_i (em_ncs4_i), .em_ncs6_i (em_ncs6_i),
      .em_nwe_i (em_nwe_i), .em_noe_i (em_noe_i),
      .em_d_o (em_d_o), .em_d_oe_o (em_d_oe_o),
      .fab_en_i (fab_en_i), .fab_we_i (fab_we_i), .fab_adr_i (fab_adr_i),
      .fab_dat_i (fab_dat_i), .fab_dat_o (fab_dat_o),
      .status_i (status_i), .ctrl_reg_o (ctrl_reg_o)
   );

   initial
   begin
      wb_clk = 1'b0;
      forever #(CLK_PERIOD/2) wb_clk = ~wb_clk;
   end

   // x^16 + x^14 + x^13 + x^11 + 1, one step per bit taken
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
         lfsr_q = {lfsr_q[14:0], fb};
         v      = {v[14:0], fb};
      end
      return v;
   endfunction

   task automatic check_data(input string what, input logic [EM_DAT_W-1:0] exp,
                             input logic [EM_DAT_W-1:0] act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         test_err++;
         $display("error %s (%s): expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_bit(input string what, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp)
      begin
         err_cnt++;
         test_err++;
         $display("error %s (%s): expected %b, actual %b", test_name, what, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err  = 0;
   endtask

   task automatic end_test();
      test_cnt++;
      if (test_err == 0)
         $display("test %s: ok", test_name);
      else
      begin
         fail_cnt++;
         $display("test %s: %0d error(s)", test_name, test_err);
      end
   endtask

   // One GPMC access, chip select first, then the strobe
   task automatic em_access(input logic cs6, input logic wr, input logic [EM_ADR_W-1:0] adr,
                            input logic [EM_DAT_W-1:0] dat, input logic [EM_SEL_W-1:0] nbe,
                            output logic [EM_DAT_W-1:0] rd);
      @(negedge wb_clk);
      em_a_i    = adr;
      em_d_i    = dat;
      em_nbe_i  = nbe;
      em_ncs4_i = cs6;
      em_ncs6_i = ~cs6;
      @(negedge wb_clk);
      em_nwe_i = ~wr;
      em_noe_i = wr;
      repeat (HOLD_CYC) @(negedge wb_clk);
      rd       = em_d_o;   // Just before the strobe rises
      em_nwe_i = 1'b1;
      em_noe_i = 1'b1;
      @(negedge wb_clk);
      em_ncs4_i = 1'b1;
      em_ncs6_i = 1'b1;
      repeat (2) @(negedge wb_clk);   // Lets the delay lines see idle
   endtask

   task automatic em_write(input logic cs6, input logic [EM_ADR_W-1:0] adr,
                           input logic [EM_DAT_W-1:0] dat, input logic [EM_SEL_W-1:0] nbe);
      logic [EM_DAT_W-1:0] unused_rd;
      em_access(cs6, 1'b1, adr, dat, nbe, unused_rd);
   endtask

   task automatic em_read(input logic cs6, input logic [EM_ADR_W-1:0] adr,
                          output logic [EM_DAT_W-1:0] rd);
      em_access(cs6, 1'b0, adr, '0, '0, rd);
   endtask

   task automatic fab_write(input logic [EM_ADR_W-1:0] adr, input logic [EM_DAT_W-1:0] dat);
      @(negedge wb_clk);
      fab_en_i  = 1'b1;
      fab_we_i  = 1'b1;
      fab_adr_i = adr;
      fab_dat_i = dat;
      @(negedge wb_clk);
      fab_en_i = 1'b0;
      fab_we_i = 1'b0;
   endtask

   task automatic fab_read(input logic [EM_ADR_W-1:0] adr, output logic [EM_DAT_W-1:0] dat);
      @(negedge wb_clk);
      fab_en_i  = 1'b1;
      fab_we_i  = 1'b0;
      fab_adr_i = adr;
      @(negedge wb_clk);
      fab_en_i = 1'b0;
      dat      = fab_dat_o;   // Registered on the edge in between
   endtask

   task automatic oe_probe(input logic ncs4, input logic ncs6, input logic exp,
                           input string what);
      @(negedge wb_clk);
      em_ncs4_i = ncs4;
      em_ncs6_i = ncs6;
      @(negedge wb_clk);
      em_noe_i = 1'b0;
      repeat (HOLD_CYC) @(negedge wb_clk);
      check_bit(what, exp, em_d_oe_o);
      em_noe_i = 1'b1;
      @(negedge wb_clk);
      check_bit({what, " released"}, 1'b0, em_d_oe_o);
      em_ncs4_i = 1'b1;
      em_ncs6_i = 1'b1;
      repeat (2) @(negedge wb_clk);
   endtask

   task automatic test_reset_idle();
      start_test("reset_idle");
      check_bit("oe after reset", 1'b0, em_d_oe_o);
      check_data("ctrl after reset", '0, ctrl_reg_o);
      oe_probe(1'b1, 1'b1, 1'b0, "oe without cs");
      oe_probe(1'b0, 1'b1, 1'b1, "oe with cs4");
      oe_probe(1'b1, 1'b0, 1'b1, "oe with cs6");
      end_test();
   endtask

   task automatic test_ram_gpmc();
      logic [EM_ADR_W-1:0] adr [NUM_WORDS];
      logic [EM_DAT_W-1:0] rd;
      start_test("ram_gpmc");
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         adr[i]            = EM_ADR_W'(rand_bits(EM_ADR_W));
         ram_model[adr[i]] = rand_bits(EM_DAT_W);
         em_write(1'b0, adr[i], ram_model[adr[i]], '0);
      end
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         em_read(1'b0, adr[i], rd);
         check_data($sformatf("cs4 read %h", adr[i]), ram_model[adr[i]], rd);
         fab_read(adr[i], rd);
         check_data($sformatf("fabric read %h", adr[i]), ram_model[adr[i]], rd);
      end
      end_test();
   endtask

   task automatic test_fabric_gpmc();
      logic [EM_ADR_W-1:0] adr [NUM_WORDS];
      logic [EM_DAT_W-1:0] rd;
      start_test("fabric_gpmc");
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         adr[i]            = EM_ADR_W'(rand_bits(EM_ADR_W));
         ram_model[adr[i]] = rand_bits(EM_DAT_W);
         fab_write(adr[i], ram_model[adr[i]]);
      end
      for (int i = 0; i < NUM_WORDS; i++)
      begin
         em_read(1'b0, adr[i], rd);
         check_data($sformatf("cs4 read %h", adr[i]), ram_model[adr[i]], rd);
      end
      end_test();
   endtask

   // Write one lane pattern to the control register and check both views
   task automatic ctrl_lane_write(input logic [EM_SEL_W-1:0] nbe);
      logic [EM_DAT_W-1:0] wr;
      logic [EM_DAT_W-1:0] rd;
      wr = rand_bits(EM_DAT_W);
      em_write(1'b1, EM_ADR_W'(REG_CTRL), wr, nbe);
      if (!nbe[0])
         ctrl_model[7:0] = wr[7:0];
      if (!nbe[1])
         ctrl_model[15:8] = wr[15:8];
      check_data($sformatf("ctrl_reg_o nbe %b", nbe), ctrl_model, ctrl_reg_o);
      em_read(1'b1, EM_ADR_W'(REG_CTRL), rd);
      check_data($sformatf("ctrl read nbe %b", nbe), ctrl_model, rd);
   endtask

   task automatic test_ctrl_lanes();
      start_test("ctrl_lanes");
      ctrl_model = '0;
      ctrl_lane_write(2'b00);
      ctrl_lane_write(2'b10);   // Low byte only
      ctrl_lane_write(2'b01);
      end_test();
   endtask

   task automatic test_read_only();
      logic [EM_DAT_W-1:0] rd;
      logic [EM_DAT_W-1:0] sts;
      start_test("read_only");
      em_read(1'b1, EM_ADR_W'(REG_ID), rd);
      check_data("id", GPMC_ID, rd);
      em_write(1'b1, EM_ADR_W'(REG_ID), ~GPMC_ID, '0);
      em_read(1'b1, EM_ADR_W'(REG_ID), rd);
      check_data("id after write", GPMC_ID, rd);
      sts = rand_bits(EM_DAT_W);
      @(negedge wb_clk);
      status_i = sts;
      em_read(1'b1, EM_ADR_W'(REG_STATUS), rd);
      check_data("status", sts, rd);
      end_test();
   endtask

   task automatic test_scratch();
      logic [EM_DAT_W-1:0] scr [3:7];
      logic [EM_DAT_W-1:0] rd;
      start_test("scratch");
      for (int i = 3; i <= 7; i++)
      begin
         scr[i] = rand_bits(EM_DAT_W);
         em_write(1'b1, EM_ADR_W'(i), scr[i], '0);
      end
      for (int i = 3; i <= 7; i++)
      begin
         em_read(1'b1, EM_ADR_W'(i), rd);
         check_data($sformatf("scratch %0d", i), scr[i], rd);
      end
      end_test();
   endtask

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYC)
      begin
         @(posedge wb_clk);
         cycle_cnt++;
      end
      $display("timeout: tests still running after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      arst_n_i  = 1'b0;
      em_a_i    = '0;
      em_d_i    = '0;
      em_nbe_i  = '1;
      em_ncs4_i = 1'b1;
      em_ncs6_i = 1'b1;
      em_nwe_i  = 1'b1;
      em_noe_i  = 1'b1;
      fab_en_i  = 1'b0;
      fab_we_i  = 1'b0;
      fab_adr_i = '0;
      fab_dat_i = '0;
      status_i  = '0;
      lfsr_q    = 16'd21;
      test_cnt  = 0;
      fail_cnt  = 0;
      check_cnt = 0;
      err_cnt   = 0;
      repeat (4) @(negedge wb_clk);
      arst_n_i = 1'b1;

      test_reset_idle();
      test_ram_gpmc();
      test_fabric_gpmc();
      test_ctrl_lanes();
      test_read_only();
      test_scratch();

      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_cnt, fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

// File: gpmc_bridge.f
verilog/gpmc_pkg.sv
verilog/ram_2port.sv
verilog/gpmc_wb_master.sv
verilog/gpmc.sv
verilog/wb_ctrl_regs.sv
verilog/gpmc_bridge_top.sv
verification/gpmc_bridge_properties.sv
verification/tb_gpmc_bridge.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the GPMC bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_gpmc_bridge \
   -f gpmc_bridge.f -Mdir obj_dir -o sim_gpmc_bridge
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_gpmc_bridge)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
   exit 0
fi
exit 1
